/* Bender.yml */
package:
  name: rv_backend

sources:
  # package first, then RTL
  - files:
      - source/rv_backend_pkg.sv
      - source/gpr_file.sv
      - source/csr_file.sv
      - source/mem_stage.sv
      - source/wb_stage.sv
      - source/rv_backend_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/rv_backend_tb.sv

/* filelist.f */
+incdir+verif
source/rv_backend_pkg.sv
source/gpr_file.sv
source/csr_file.sv
source/mem_stage.sv
source/wb_stage.sv
source/rv_backend_top.sv
verif/rv_backend_tb.sv

/* source/csr_file.sv */
// machine CSR file: mstatus, mtvec, mepc and mcause with masked mstatus writes
`default_nettype none

module csr_file (
  input  wire                                i_clk,
  input  wire                                i_rst_n,
  input  wire                                i_we,
  input  wire  [rv_backend_pkg::CSR_AW-1:0]  i_waddr,
  input  wire  [rv_backend_pkg::XLEN-1:0]    i_wdata,
  input  wire  [rv_backend_pkg::CSR_AW-1:0]  i_raddr,
  output logic [rv_backend_pkg::XLEN-1:0]    o_rdata
);

  rv_backend_pkg::mstatus_u        mstatus;
  logic [rv_backend_pkg::XLEN-1:0] mtvec;
  logic [rv_backend_pkg::XLEN-1:0] mepc;
  logic [rv_backend_pkg::XLEN-1:0] mcause;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mstatus.raw <= '0;
      mtvec       <= '0;
      mepc        <= '0;
      mcause      <= '0;
    end else if (i_we) begin
      case (i_waddr)
        rv_backend_pkg::CSR_MSTATUS: mstatus.raw <= i_wdata & rv_backend_pkg::MSTATUS_WMASK;
        // direct mode only, base is word aligned
        rv_backend_pkg::CSR_MTVEC:   mtvec <= {i_wdata[rv_backend_pkg::XLEN-1:2], 2'b00};
        rv_backend_pkg::CSR_MEPC:    mepc <= {i_wdata[rv_backend_pkg::XLEN-1:1], 1'b0};
        rv_backend_pkg::CSR_MCAUSE:  mcause <= i_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      rv_backend_pkg::CSR_MSTATUS: o_rdata = mstatus.raw;
      rv_backend_pkg::CSR_MTVEC:   o_rdata = mtvec;
      rv_backend_pkg::CSR_MEPC:    o_rdata = mepc;
      rv_backend_pkg::CSR_MCAUSE:  o_rdata = mcause;
      default:                     o_rdata = '0;
    endcase
  end

  // reserved mstatus fields never pick up a written one
  mstatus_rsvd_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (mstatus.f.rsvd_31_13 == '0) && (mstatus.f.rsvd_10_8 == '0) &&
    (mstatus.f.rsvd_6_4 == '0) && (mstatus.f.rsvd_2_0 == '0));

endmodule

`default_nettype wire

/* source/gpr_file.sv */
// general-purpose register file: 32 x 32 bits, two read ports, x0 hard-wired to zero
`default_nettype none

module gpr_file (
  input  wire                                i_clk,
  input  wire                                i_rst_n,
  input  wire                                i_we,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]  i_waddr,
  input  wire  [rv_backend_pkg::XLEN-1:0]    i_wdata,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]  i_raddr1,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]  i_raddr2,
  output logic [rv_backend_pkg::XLEN-1:0]    o_rdata1,
  output logic [rv_backend_pkg::XLEN-1:0]    o_rdata2
);

  // no storage behind x0
  logic [rv_backend_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  always_comb begin
    if (i_raddr1 == '0) begin
      o_rdata1 = '0;
    end else begin
      o_rdata1 = regs[i_raddr1];
    end
  end

  always_comb begin
    if (i_raddr2 == '0) begin
      o_rdata2 = '0;
    end else begin
      o_rdata2 = regs[i_raddr2];
    end
  end

  // a write to x1..x31 is held in the array on the next cycle
  write_lands: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_we && (i_waddr != '0)) |=> (regs[$past(i_waddr)] == $past(i_wdata)));

endmodule

`default_nettype wire

/* source/mem_stage.sv */
// memory stage: takes execute results, issues data-memory reads and aligns load data
`default_nettype none

module mem_stage (
  input  wire                                  i_clk,
  input  wire                                  i_rst_n,
  // from execute
  input  wire                                  i_es_to_ms_valid,
  input  wire                                  i_es_gpr_wen,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]    i_es_rd,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_alu_result,
  input  wire                                  i_es_is_load,
  input  wire  [rv_backend_pkg::MEM_OP_W-1:0]  i_es_mem_op,
  input  wire                                  i_es_csr_wen,
  input  wire  [rv_backend_pkg::CSR_AW-1:0]    i_es_csr_addr,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_csr_wdata,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_pc,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_inst,
  output logic                                 o_ms_allowin,
  // data memory
  output logic                                 o_dmem_ren,
  output logic [rv_backend_pkg::XLEN-3:0]      o_dmem_addr,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_dmem_rdata,
  // to write-back
  input  wire                                  i_ws_allowin,
  output logic                                 o_ms_to_ws_valid,
  output logic                                 o_ms_gpr_wen,
  output logic [rv_backend_pkg::GPR_AW-1:0]    o_ms_rd,
  output logic [rv_backend_pkg::XLEN-1:0]      o_ms_gpr_wdata,
  output logic                                 o_ms_csr_wen,
  output logic [rv_backend_pkg::CSR_AW-1:0]    o_ms_csr_addr,
  output logic [rv_backend_pkg::XLEN-1:0]      o_ms_csr_wdata,
  output logic [rv_backend_pkg::XLEN-1:0]      o_ms_pc,
  output logic [rv_backend_pkg::XLEN-1:0]      o_ms_inst,
  // pending destinations for decode interlock
  output logic [rv_backend_pkg::GPR_AW-1:0]    o_ms_gpr_rd,
  output logic [rv_backend_pkg::CSR_AW-1:0]    o_ms_csr_rd
);

  logic                                ms_valid;
  logic                                ms_ready_go;
  logic                                es_to_ms_fire;
  logic                                ms_gpr_wen;
  logic [rv_backend_pkg::GPR_AW-1:0]   ms_rd;
  logic [rv_backend_pkg::XLEN-1:0]     ms_alu_result;
  logic                                ms_is_load;
  logic [rv_backend_pkg::MEM_OP_W-1:0] ms_mem_op;
  logic [7:0]                          load_byte;
  logic [15:0]                         load_half;
  logic [rv_backend_pkg::XLEN-1:0]     load_data;

  assign ms_ready_go   = 1'b1;
  assign o_ms_allowin  = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign es_to_ms_fire = i_es_to_ms_valid && o_ms_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (es_to_ms_fire) begin
      ms_gpr_wen     <= i_es_gpr_wen;
      ms_rd          <= i_es_rd;
      ms_alu_result  <= i_es_alu_result;
      ms_is_load     <= i_es_is_load;
      ms_mem_op      <= i_es_mem_op;
      o_ms_csr_wen   <= i_es_csr_wen;
      o_ms_csr_addr  <= i_es_csr_addr;
      o_ms_csr_wdata <= i_es_csr_wdata;
      o_ms_pc        <= i_es_pc;
      o_ms_inst      <= i_es_inst;
    end
  end

  // read goes out in the accept cycle, data returns while the item sits here
  assign o_dmem_ren  = es_to_ms_fire && i_es_is_load;
  assign o_dmem_addr = i_es_alu_result[rv_backend_pkg::XLEN-1:2];

  // lane select from the registered address low bits
  assign load_byte = i_dmem_rdata[{ms_alu_result[1:0], 3'b000} +: 8];
  assign load_half = i_dmem_rdata[{ms_alu_result[1], 4'b0000} +: 16];

  always_comb begin
    case (ms_mem_op)
      rv_backend_pkg::MEM_LB:  load_data = {{(rv_backend_pkg::XLEN-8){load_byte[7]}}, load_byte};
      rv_backend_pkg::MEM_LBU: load_data = {{(rv_backend_pkg::XLEN-8){1'b0}}, load_byte};
      rv_backend_pkg::MEM_LH:  load_data = {{(rv_backend_pkg::XLEN-16){load_half[15]}}, load_half};
      rv_backend_pkg::MEM_LHU: load_data = {{(rv_backend_pkg::XLEN-16){1'b0}}, load_half};
      default:                 load_data = i_dmem_rdata;
    endcase
  end

  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;
  assign o_ms_gpr_wen     = ms_gpr_wen;
  assign o_ms_rd          = ms_rd;
  assign o_ms_gpr_wdata   = ms_is_load ? load_data : ms_alu_result;

  assign o_ms_gpr_rd = {rv_backend_pkg::GPR_AW{ms_valid && ms_gpr_wen}} & ms_rd;
  assign o_ms_csr_rd = {rv_backend_pkg::CSR_AW{ms_valid && o_ms_csr_wen}} & o_ms_csr_addr;

  // returning read data always lands on a load held in this stage
  ren_data_has_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_dmem_ren |=> (ms_valid && ms_is_load));

endmodule

`default_nettype wire

/* source/rv_backend_pkg.sv */
// rv backend package: RV32 widths, load-size codes, CSR map and mstatus layout
`default_nettype none

package rv_backend_pkg;

  localparam int XLEN     = 32;
  localparam int GPR_AW   = 5;
  localparam int CSR_AW   = 12;
  localparam int MEM_OP_W = 3;

  // load-size codes, funct3 of the load opcode
  localparam logic [MEM_OP_W-1:0] MEM_LB  = 3'd0;
  localparam logic [MEM_OP_W-1:0] MEM_LH  = 3'd1;
  localparam logic [MEM_OP_W-1:0] MEM_LW  = 3'd2;
  localparam logic [MEM_OP_W-1:0] MEM_LBU = 3'd4;
  localparam logic [MEM_OP_W-1:0] MEM_LHU = 3'd5;

  // machine CSR addresses
  localparam logic [CSR_AW-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_AW-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_AW-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_AW-1:0] CSR_MCAUSE  = 12'h342;

  // MPP, MPIE and MIE are the only writable mstatus bits
  localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;

  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic [18:0] rsvd_31_13;
      logic [1:0]  mpp;
      logic [2:0]  rsvd_10_8;
      logic        mpie;
      logic [2:0]  rsvd_6_4;
      logic        mie;
      logic [2:0]  rsvd_2_0;
    } f;
  } mstatus_u;

endpackage

`default_nettype wire

/* source/rv_backend_top.sv */
// rv backend top: memory and write-back stages with the GPR and CSR files
`default_nettype none

module rv_backend_top (
  input  wire                                  i_clk,
  input  wire                                  i_rst_n,
  // execute handoff
  input  wire                                  i_es_to_ms_valid,
  input  wire                                  i_es_gpr_wen,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]    i_es_rd,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_alu_result,
  input  wire                                  i_es_is_load,
  input  wire  [rv_backend_pkg::MEM_OP_W-1:0]  i_es_mem_op,
  input  wire                                  i_es_csr_wen,
  input  wire  [rv_backend_pkg::CSR_AW-1:0]    i_es_csr_addr,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_csr_wdata,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_pc,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_es_inst,
  output wire                                  o_ms_allowin,
  // data memory
  output wire                                  o_dmem_ren,
  output wire  [rv_backend_pkg::XLEN-3:0]      o_dmem_addr,
  input  wire  [rv_backend_pkg::XLEN-1:0]      i_dmem_rdata,
  // register read ports
  input  wire  [rv_backend_pkg::GPR_AW-1:0]    i_gpr_raddr1,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]    i_gpr_raddr2,
  output wire  [rv_backend_pkg::XLEN-1:0]      o_gpr_rdata1,
  output wire  [rv_backend_pkg::XLEN-1:0]      o_gpr_rdata2,
  input  wire  [rv_backend_pkg::CSR_AW-1:0]    i_csr_raddr,
  output wire  [rv_backend_pkg::XLEN-1:0]      o_csr_rdata,
  // hazard destinations
  output wire  [rv_backend_pkg::GPR_AW-1:0]    o_ms_gpr_rd,
  output wire  [rv_backend_pkg::CSR_AW-1:0]    o_ms_csr_rd,
  output wire  [rv_backend_pkg::GPR_AW-1:0]    o_ws_gpr_rd,
  output wire  [rv_backend_pkg::CSR_AW-1:0]    o_ws_csr_rd,
  // commit trace
  output wire                                  o_commit_valid,
  output wire  [rv_backend_pkg::XLEN-1:0]      o_commit_pc,
  output wire  [rv_backend_pkg::XLEN-1:0]      o_commit_inst
);

  wire                               ws_allowin;
  wire                               ms_to_ws_valid;
  wire                               ms_gpr_wen;
  wire [rv_backend_pkg::GPR_AW-1:0]  ms_rd;
  wire [rv_backend_pkg::XLEN-1:0]    ms_gpr_wdata;
  wire                               ms_csr_wen;
  wire [rv_backend_pkg::CSR_AW-1:0]  ms_csr_addr;
  wire [rv_backend_pkg::XLEN-1:0]    ms_csr_wdata;
  wire [rv_backend_pkg::XLEN-1:0]    ms_pc;
  wire [rv_backend_pkg::XLEN-1:0]    ms_inst;
  wire                               gpr_we;
  wire [rv_backend_pkg::GPR_AW-1:0]  gpr_waddr;
  wire [rv_backend_pkg::XLEN-1:0]    gpr_wdata;
  wire                               csr_we;
  wire [rv_backend_pkg::CSR_AW-1:0]  csr_waddr;
  wire [rv_backend_pkg::XLEN-1:0]    csr_wdata;

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_es_to_ms_valid (i_es_to_ms_valid),
    .i_es_gpr_wen     (i_es_gpr_wen),
    .i_es_rd          (i_es_rd),
    .i_es_alu_result  (i_es_alu_result),
    .i_es_is_load     (i_es_is_load),
    .i_es_mem_op      (i_es_mem_op),
    .i_es_csr_wen     (i_es_csr_wen),
    .i_es_csr_addr    (i_es_csr_addr),
    .i_es_csr_wdata   (i_es_csr_wdata),
    .i_es_pc          (i_es_pc),
    .i_es_inst        (i_es_inst),
    .o_ms_allowin     (o_ms_allowin),
    .o_dmem_ren       (o_dmem_ren),
    .o_dmem_addr      (o_dmem_addr),
    .i_dmem_rdata     (i_dmem_rdata),
    .i_ws_allowin     (ws_allowin),
    .o_ms_to_ws_valid (ms_to_ws_valid),
    .o_ms_gpr_wen     (ms_gpr_wen),
    .o_ms_rd          (ms_rd),
    .o_ms_gpr_wdata   (ms_gpr_wdata),
    .o_ms_csr_wen     (ms_csr_wen),
    .o_ms_csr_addr    (ms_csr_addr),
    .o_ms_csr_wdata   (ms_csr_wdata),
    .o_ms_pc          (ms_pc),
    .o_ms_inst        (ms_inst),
    .o_ms_gpr_rd      (o_ms_gpr_rd),
    .o_ms_csr_rd      (o_ms_csr_rd)
  );

  wb_stage u_wb_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .o_ws_allowin     (ws_allowin),
    .i_ms_to_ws_valid (ms_to_ws_valid),
    .i_ms_gpr_wen     (ms_gpr_wen),
    .i_ms_rd          (ms_rd),
    .i_ms_gpr_wdata   (ms_gpr_wdata),
    .i_ms_csr_wen     (ms_csr_wen),
    .i_ms_csr_addr    (ms_csr_addr),
    .i_ms_csr_wdata   (ms_csr_wdata),
    .i_ms_pc          (ms_pc),
    .i_ms_inst        (ms_inst),
    .o_gpr_we         (gpr_we),
    .o_gpr_waddr      (gpr_waddr),
    .o_gpr_wdata      (gpr_wdata),
    .o_csr_we         (csr_we),
    .o_csr_waddr      (csr_waddr),
    .o_csr_wdata      (csr_wdata),
    .o_ws_gpr_rd      (o_ws_gpr_rd),
    .o_ws_csr_rd      (o_ws_csr_rd),
    .o_commit_valid   (o_commit_valid),
    .o_commit_pc      (o_commit_pc),
    .o_commit_inst    (o_commit_inst)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_we     (gpr_we),
    .i_waddr  (gpr_waddr),
    .i_wdata  (gpr_wdata),
    .i_raddr1 (i_gpr_raddr1),
    .i_raddr2 (i_gpr_raddr2),
    .o_rdata1 (o_gpr_rdata1),
    .o_rdata2 (o_gpr_rdata2)
  );

  csr_file u_csr_file (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_we    (csr_we),
    .i_waddr (csr_waddr),
    .i_wdata (csr_wdata),
    .i_raddr (i_csr_raddr),
    .o_rdata (o_csr_rdata)
  );

endmodule

`default_nettype wire

/* source/wb_stage.sv */
// write-back stage: commits memory-stage results to the register files and traces them
`default_nettype none

module wb_stage (
  input  wire                                i_clk,
  input  wire                                i_rst_n,
  output logic                               o_ws_allowin,
  // from memory stage
  input  wire                                i_ms_to_ws_valid,
  input  wire                                i_ms_gpr_wen,
  input  wire  [rv_backend_pkg::GPR_AW-1:0]  i_ms_rd,
  input  wire  [rv_backend_pkg::XLEN-1:0]    i_ms_gpr_wdata,
  input  wire                                i_ms_csr_wen,
  input  wire  [rv_backend_pkg::CSR_AW-1:0]  i_ms_csr_addr,
  input  wire  [rv_backend_pkg::XLEN-1:0]    i_ms_csr_wdata,
  input  wire  [rv_backend_pkg::XLEN-1:0]    i_ms_pc,
  input  wire  [rv_backend_pkg::XLEN-1:0]    i_ms_inst,
  // register file writes
  output logic                               o_gpr_we,
  output logic [rv_backend_pkg::GPR_AW-1:0]  o_gpr_waddr,
  output logic [rv_backend_pkg::XLEN-1:0]    o_gpr_wdata,
  output logic                               o_csr_we,
  output logic [rv_backend_pkg::CSR_AW-1:0]  o_csr_waddr,
  output logic [rv_backend_pkg::XLEN-1:0]    o_csr_wdata,
  // pending destinations
  output logic [rv_backend_pkg::GPR_AW-1:0]  o_ws_gpr_rd,
  output logic [rv_backend_pkg::CSR_AW-1:0]  o_ws_csr_rd,
  // commit trace
  output logic                               o_commit_valid,
  output logic [rv_backend_pkg::XLEN-1:0]    o_commit_pc,
  output logic [rv_backend_pkg::XLEN-1:0]    o_commit_inst
);

  logic ws_valid;
  logic ws_ready_go;
  logic ws_gpr_wen;
  logic ws_csr_wen;

  // last stage, nothing downstream to wait for
  assign ws_ready_go  = 1'b1;
  assign o_ws_allowin = !ws_valid || ws_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ws_valid <= 1'b0;
    end else if (o_ws_allowin) begin
      ws_valid <= i_ms_to_ws_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ms_to_ws_valid && o_ws_allowin) begin
      ws_gpr_wen    <= i_ms_gpr_wen;
      o_gpr_waddr   <= i_ms_rd;
      o_gpr_wdata   <= i_ms_gpr_wdata;
      ws_csr_wen    <= i_ms_csr_wen;
      o_csr_waddr   <= i_ms_csr_addr;
      o_csr_wdata   <= i_ms_csr_wdata;
      o_commit_pc   <= i_ms_pc;
      o_commit_inst <= i_ms_inst;
    end
  end

  assign o_gpr_we       = ws_valid && ws_gpr_wen;
  assign o_csr_we       = ws_valid && ws_csr_wen;
  assign o_commit_valid = ws_valid;

  assign o_ws_gpr_rd = {rv_backend_pkg::GPR_AW{o_gpr_we}} & o_gpr_waddr;
  assign o_ws_csr_rd = {rv_backend_pkg::CSR_AW{o_csr_we}} & o_csr_waddr;

  // every accepted item shows up in the trace on the next cycle
  accept_is_committed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ms_to_ws_valid && o_ws_allowin) |=> o_commit_valid);

endmodule

`default_nettype wire

/* verif/rv_backend_tests.svh */
// directed tests for the back end: write-back, loads, x0, CSRs, hazards and commit trace

// back-to-back ALU results, then every written register read back
task automatic test_alu_writeback();
  logic [31:0] exp_regs [32];
  logic        written [32];
  logic [4:0]  rd;
  logic [31:0] data;
  logic [31:0] got;
  int          i;
  for (i = 0; i < 32; i++) begin
    exp_regs[i] = '0;
    written[i]  = 1'b0;
  end
  commit_pc_q.delete();
  for (i = 0; i < 20; i++) begin
    rd           = 5'(next_rand() % 32'd31 + 32'd1);
    data         = next_rand();
    exp_regs[rd] = data;
    written[rd]  = 1'b1;
    issue_item(1'b1, rd, data, 1'b0, rv_backend_pkg::MEM_LW, 1'b0, '0, '0,
               32'h0000_1000 + 32'(4 * i), next_rand());
  end
  wait_commits("alu_writeback", 20);
  compare_commit_pcs("alu_writeback", 32'h0000_1000, 20);
  for (i = 1; i < 32; i++) begin
    if (written[i]) begin
      read_gpr(5'(i), got);
      if (got !== exp_regs[i]) begin
        report_mismatch("alu_writeback", exp_regs[i], got);
      end
      read_gpr_port2(5'(i), got);
      if (got !== exp_regs[i]) begin
        report_mismatch("alu_writeback", exp_regs[i], got);
      end
    end
  end
endtask

// every load size at every aligned offset
task automatic test_loads();
  logic [2:0]  ops [5];
  logic [31:0] addr;
  logic [31:0] word;
  logic [31:0] lane;
  logic [31:0] expected;
  logic [31:0] got;
  int          o;
  int          off;
  int          step;
  ops = '{rv_backend_pkg::MEM_LB, rv_backend_pkg::MEM_LH, rv_backend_pkg::MEM_LW,
          rv_backend_pkg::MEM_LBU, rv_backend_pkg::MEM_LHU};
  for (o = 0; o < 5; o++) begin
    if (ops[o] == rv_backend_pkg::MEM_LW) begin
      step = 4;
    end else if (ops[o] == rv_backend_pkg::MEM_LH || ops[o] == rv_backend_pkg::MEM_LHU) begin
      step = 2;
    end else begin
      step = 1;
    end
    for (off = 0; off < 4; off += step) begin
      addr = (next_rand() & 32'hFFFF_FFFC) | 32'(off);
      word = mem_word(addr[31:2]);
      lane = word >> (8 * off);
      case (ops[o])
        rv_backend_pkg::MEM_LB:  expected = {{24{lane[7]}}, lane[7:0]};
        rv_backend_pkg::MEM_LBU: expected = {24'h0, lane[7:0]};
        rv_backend_pkg::MEM_LH:  expected = {{16{lane[15]}}, lane[15:0]};
        rv_backend_pkg::MEM_LHU: expected = {16'h0, lane[15:0]};
        default:                 expected = word;
      endcase
      commit_pc_q.delete();
      // load to x10 with the size in funct3
      issue_item(1'b1, 5'd10, addr, 1'b1, ops[o], 1'b0, '0, '0, 32'h0000_2000,
                 {17'd0, ops[o], 5'd10, 7'b0000011});
      wait_commits("loads", 1);
      read_gpr(5'd10, got);
      if (got !== expected) begin
        report_mismatch("loads", expected, got);
      end
    end
  end
endtask

task automatic test_x0();
  logic [31:0] got;
  commit_pc_q.delete();
  issue_item(1'b1, 5'd0, 32'hDEAD_BEEF, 1'b0, rv_backend_pkg::MEM_LW, 1'b0, '0, '0,
             32'h0000_3000, 32'h0000_0013);
  wait_commits("x0", 1);
  read_gpr(5'd0, got);
  if (got !== 32'h0) begin
    report_mismatch("x0", 32'h0, got);
  end
endtask

task automatic test_csr();
  logic [11:0] addrs [5];
  logic [31:0] wdata [5];
  logic [31:0] expected [5];
  logic [31:0] got;
  int          i;
  addrs = '{rv_backend_pkg::CSR_MSTATUS, rv_backend_pkg::CSR_MTVEC, rv_backend_pkg::CSR_MEPC,
            rv_backend_pkg::CSR_MCAUSE, 12'h7C0};
  wdata[0] = 32'hFFFF_FFFF;
  wdata[1] = next_rand() | 32'h3;
  wdata[2] = next_rand() | 32'h1;
  wdata[3] = next_rand();
  wdata[4] = next_rand();
  // MIE, MPIE and MPP survive
  expected[0] = (32'h1 << 3) | (32'h1 << 7) | (32'h3 << 11);
  expected[1] = wdata[1] & ~32'h3;
  expected[2] = wdata[2] & ~32'h1;
  expected[3] = wdata[3];
  // unmapped address
  expected[4] = 32'h0;
  for (i = 0; i < 5; i++) begin
    commit_pc_q.delete();
    issue_item(1'b0, 5'd0, 32'h0, 1'b0, rv_backend_pkg::MEM_LW, 1'b1, addrs[i], wdata[i],
               32'h0000_3100 + 32'(4 * i), 32'h0000_1073);
    wait_commits("csr", 1);
    read_csr(addrs[i], got);
    if (got !== expected[i]) begin
      report_mismatch("csr", expected[i], got);
    end
  end
endtask

task automatic test_hazard_commit();
  int i;
  commit_pc_q.delete();
  issue_item(1'b1, 5'd7, 32'h55, 1'b0, rv_backend_pkg::MEM_LW, 1'b1, rv_backend_pkg::CSR_MCAUSE,
             32'h0B, 32'h0000_4000, 32'h0070_0393);
  // memory stage cycle
  if (ms_gpr_rd !== 5'd7) report_mismatch("hazard_commit", 5'd7, ms_gpr_rd);
  if (ms_csr_rd !== rv_backend_pkg::CSR_MCAUSE) begin
    report_mismatch("hazard_commit", rv_backend_pkg::CSR_MCAUSE, ms_csr_rd);
  end
  @(negedge clk);
  // write-back cycle, bubble behind it
  if (ws_gpr_rd !== 5'd7) report_mismatch("hazard_commit", 5'd7, ws_gpr_rd);
  if (ws_csr_rd !== rv_backend_pkg::CSR_MCAUSE) begin
    report_mismatch("hazard_commit", rv_backend_pkg::CSR_MCAUSE, ws_csr_rd);
  end
  if (commit_valid !== 1'b1) report_mismatch("hazard_commit", 1'b1, commit_valid);
  if (commit_pc !== 32'h0000_4000) report_mismatch("hazard_commit", 32'h0000_4000, commit_pc);
  if (commit_inst !== 32'h0070_0393) report_mismatch("hazard_commit", 32'h0070_0393, commit_inst);
  if (ms_gpr_rd !== 5'd0) report_mismatch("hazard_commit", 5'd0, ms_gpr_rd);
  // no writes pending, destinations masked
  issue_item(1'b0, 5'd9, 32'h66, 1'b0, rv_backend_pkg::MEM_LW, 1'b0, 12'h305, 32'h0,
             32'h0000_4004, 32'h0000_0013);
  if (ms_gpr_rd !== 5'd0) report_mismatch("hazard_commit", 5'd0, ms_gpr_rd);
  if (ms_csr_rd !== 12'd0) report_mismatch("hazard_commit", 12'd0, ms_csr_rd);
  @(negedge clk);
  if (ws_gpr_rd !== 5'd0) report_mismatch("hazard_commit", 5'd0, ws_gpr_rd);
  if (ws_csr_rd !== 12'd0) report_mismatch("hazard_commit", 12'd0, ws_csr_rd);
  if (commit_valid !== 1'b1) report_mismatch("hazard_commit", 1'b1, commit_valid);
  if (commit_pc !== 32'h0000_4004) report_mismatch("hazard_commit", 32'h0000_4004, commit_pc);
  wait_commits("hazard_commit", 2);
  commit_pc_q.delete();
  for (i = 0; i < 3; i++) begin
    issue_item(1'b1, 5'(i + 1), next_rand(), 1'b0, rv_backend_pkg::MEM_LW, 1'b0, '0, '0,
               32'h0000_5000 + 32'(4 * i), next_rand());
  end
  wait_commits("hazard_commit", 3);
  compare_commit_pcs("hazard_commit", 32'h0000_5000, 3);
endtask

/* verif/rv_backend_tb.sv */
// backend testbench: drives execute handoffs into the back end and models the data memory
`default_nettype none

module rv_backend_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD     = 20;
  localparam int          TIMEOUT_CYCLES = 50;
  localparam logic [31:0] SEED           = 32'd66;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 es_valid;
  logic                                 es_gpr_wen;
  logic [rv_backend_pkg::GPR_AW-1:0]    es_rd;
  logic [rv_backend_pkg::XLEN-1:0]      es_alu_result;
  logic                                 es_is_load;
  logic [rv_backend_pkg::MEM_OP_W-1:0]  es_mem_op;
  logic                                 es_csr_wen;
  logic [rv_backend_pkg::CSR_AW-1:0]    es_csr_addr;
  logic [rv_backend_pkg::XLEN-1:0]      es_csr_wdata;
  logic [rv_backend_pkg::XLEN-1:0]      es_pc;
  logic [rv_backend_pkg::XLEN-1:0]      es_inst;
  logic [rv_backend_pkg::XLEN-1:0]      dmem_rdata;
  logic [rv_backend_pkg::GPR_AW-1:0]    gpr_raddr1;
  logic [rv_backend_pkg::GPR_AW-1:0]    gpr_raddr2;
  logic [rv_backend_pkg::CSR_AW-1:0]    csr_raddr;
  wire                                  ms_allowin;
  wire                                  dmem_ren;
  wire  [rv_backend_pkg::XLEN-3:0]      dmem_addr;
  wire  [rv_backend_pkg::XLEN-1:0]      gpr_rdata1;
  wire  [rv_backend_pkg::XLEN-1:0]      gpr_rdata2;
  wire  [rv_backend_pkg::XLEN-1:0]      csr_rdata;
  wire  [rv_backend_pkg::GPR_AW-1:0]    ms_gpr_rd;
  wire  [rv_backend_pkg::CSR_AW-1:0]    ms_csr_rd;
  wire  [rv_backend_pkg::GPR_AW-1:0]    ws_gpr_rd;
  wire  [rv_backend_pkg::CSR_AW-1:0]    ws_csr_rd;
  wire                                  commit_valid;
  wire  [rv_backend_pkg::XLEN-1:0]      commit_pc;
  wire  [rv_backend_pkg::XLEN-1:0]      commit_inst;

  int          check_errors;
  int          timeout_errors;
  logic [31:0] rand_state;
  logic [31:0] commit_pc_q [$];

  rv_backend_top DUT (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_es_to_ms_valid (es_valid),
    .i_es_gpr_wen     (es_gpr_wen),
    .i_es_rd          (es_rd),
    .i_es_alu_result  (es_alu_result),
    .i_es_is_load     (es_is_load),
    .i_es_mem_op      (es_mem_op),
    .i_es_csr_wen     (es_csr_wen),
    .i_es_csr_addr    (es_csr_addr),
    .i_es_csr_wdata   (es_csr_wdata),
    .i_es_pc          (es_pc),
    .i_es_inst        (es_inst),
    .o_ms_allowin     (ms_allowin),
    .o_dmem_ren       (dmem_ren),
    .o_dmem_addr      (dmem_addr),
    .i_dmem_rdata     (dmem_rdata),
    .i_gpr_raddr1     (gpr_raddr1),
    .i_gpr_raddr2     (gpr_raddr2),
    .o_gpr_rdata1     (gpr_rdata1),
    .o_gpr_rdata2     (gpr_rdata2),
    .i_csr_raddr      (csr_raddr),
    .o_csr_rdata      (csr_rdata),
    .o_ms_gpr_rd      (ms_gpr_rd),
    .o_ms_csr_rd      (ms_csr_rd),
    .o_ws_gpr_rd      (ws_gpr_rd),
    .o_ws_csr_rd      (ws_csr_rd),
    .o_commit_valid   (commit_valid),
    .o_commit_pc      (commit_pc),
    .o_commit_inst    (commit_inst)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rand_state = lcg_step(rand_state);
    return rand_state;
  endfunction

  // memory contents follow from the word address alone
  function automatic logic [31:0] mem_word(input logic [rv_backend_pkg::XLEN-3:0] waddr);
    return lcg_step({2'b00, waddr});
  endfunction

  // data memory, one cycle read latency
  always @(posedge clk) begin
    if (!rst_n) begin
      dmem_rdata <= '0;
    end else if (dmem_ren) begin
      dmem_rdata <= mem_word(dmem_addr);
    end
  end

  // commit trace, in order of appearance
  always @(posedge clk) begin
    if (rst_n && commit_valid) begin
      commit_pc_q.push_back(commit_pc);
    end
  end

  task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    check_errors++;
    $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
  endtask

  task automatic report_timeout(input string test_name, input string what);
    timeout_errors++;
    $display("%s timed out waiting for %s", test_name, what);
  endtask

  task automatic idle_inputs();
    es_valid      = 1'b0;
    es_gpr_wen    = 1'b0;
    es_rd         = '0;
    es_alu_result = '0;
    es_is_load    = 1'b0;
    es_mem_op     = '0;
    es_csr_wen    = 1'b0;
    es_csr_addr   = '0;
    es_csr_wdata  = '0;
    es_pc         = '0;
    es_inst       = '0;
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic issue_item(input logic gpr_wen, input logic [4:0] rd, input logic [31:0] alu,
                            input logic is_load, input logic [2:0] mem_op,
                            input logic csr_wen, input logic [11:0] csr_addr,
                            input logic [31:0] csr_wdata, input logic [31:0] pc,
                            input logic [31:0] inst);
    int waited;
    es_gpr_wen    = gpr_wen;
    es_rd         = rd;
    es_alu_result = alu;
    es_is_load    = is_load;
    es_mem_op     = mem_op;
    es_csr_wen    = csr_wen;
    es_csr_addr   = csr_addr;
    es_csr_wdata  = csr_wdata;
    es_pc         = pc;
    es_inst       = inst;
    es_valid      = 1'b1;
    waited        = 0;
    while (!ms_allowin && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!ms_allowin) begin
      report_timeout("issue_item", "o_ms_allowin");
    end else begin
      @(negedge clk);
    end
    es_valid = 1'b0;
  endtask

  task automatic wait_commits(input string test_name, input int count);
    int waited;
    waited = 0;
    while (commit_pc_q.size() < count && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (commit_pc_q.size() < count) begin
      report_timeout(test_name, "commit trace");
    end
  endtask

  // pcs are expected to step by one word from first_pc
  task automatic compare_commit_pcs(input string test_name, input logic [31:0] first_pc,
                                    input int count);
    int i;
    if (commit_pc_q.size() != count) begin
      report_mismatch(test_name, count, commit_pc_q.size());
    end
    for (i = 0; i < count && i < commit_pc_q.size(); i++) begin
      if (commit_pc_q[i] !== first_pc + 32'(4 * i)) begin
        report_mismatch(test_name, first_pc + 32'(4 * i), commit_pc_q[i]);
      end
    end
  endtask

  task automatic read_gpr(input logic [4:0] addr, output logic [31:0] data);
    gpr_raddr1 = addr;
    #1;
    data = gpr_rdata1;
    @(negedge clk);
  endtask

  task automatic read_gpr_port2(input logic [4:0] addr, output logic [31:0] data);
    gpr_raddr2 = addr;
    #1;
    data = gpr_rdata2;
    @(negedge clk);
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    csr_raddr = addr;
    #1;
    data = csr_rdata;
    @(negedge clk);
  endtask

  `include "rv_backend_tests.svh"

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    dmem_rdata     = '0;
    gpr_raddr1     = '0;
    gpr_raddr2     = '0;
    csr_raddr      = '0;
    check_errors   = 0;
    timeout_errors = 0;
    rand_state     = SEED;
    idle_inputs();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_alu_writeback();
    test_loads();
    test_x0();
    test_csr();
    test_hazard_commit();
    $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
